// File: common/isa_pkg.sv
package isa_pkg;

    // Datapath and instruction word width
    localparam int XLEN = 32;

    // RV32E register index, low four bits of each register field
    localparam int REG_ADDR_W = 4;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        R    = 3'd1,
        I    = 3'd2,
        S    = 3'd3,
        B    = 3'd4,
        U    = 3'd5,
        J    = 3'd6
    } fmt_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word, register view and immediate view
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        // imm12 doubles as the CSR address for SYSTEM words
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } inst_u;

endpackage

// File: common/csr_pkg.sv
package csr_pkg;

    localparam int CSR_ADDR_W = 12;

    // Machine CSRs held by the decode stage
    localparam int NR_CSRS = 4;

    typedef enum logic [CSR_ADDR_W-1:0] {
        MSTATUS = 12'h300,
        MTVEC   = 12'h305,
        MEPC    = 12'h341,
        MCAUSE  = 12'h342
    } csr_addr_e;

    // MPP = machine mode
    localparam logic [31:0] MSTATUS_RESET = 32'h0000_1800;

endpackage

// File: common/commit_if.sv
`timescale 1ns/1ps

interface commit_if;

    logic [isa_pkg::XLEN-1:0] wb_data;
    logic                     gpr_we;
    logic                     csr_we;
    logic                     irq;
    logic [isa_pkg::XLEN-1:0] irq_cause;
    logic [isa_pkg::XLEN-1:0] pc;

    // Enables already qualified with the accept cycle
    modport wrapper (output wb_data, gpr_we, csr_we, irq, irq_cause, pc);
    modport core (input wb_data, gpr_we, csr_we, irq, irq_cause, pc);

endinterface

// File: idu/gpr_file.sv
`timescale 1ns/1ps

module gpr_file #(
    parameter int NR_REGS = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [$clog2(NR_REGS)-1:0] raddr1,
    input  logic [$clog2(NR_REGS)-1:0] raddr2,
    input  logic [$clog2(NR_REGS)-1:0] waddr,
    input  logic [isa_pkg::XLEN-1:0]   wdata,
    input  logic                       we,
    output logic [isa_pkg::XLEN-1:0]   rdata1,
    output logic [isa_pkg::XLEN-1:0]   rdata2
);

    logic [isa_pkg::XLEN-1:0] regs_q [NR_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs_q[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs_q[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs_q[raddr2];

endmodule

// File: idu/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr,
    input  logic [isa_pkg::XLEN-1:0]     wdata,
    input  logic                         we,
    input  logic                         irq,
    input  logic [isa_pkg::XLEN-1:0]     irq_cause,
    input  logic [isa_pkg::XLEN-1:0]     pc,
    output logic [isa_pkg::XLEN-1:0]     rdata,
    output logic [isa_pkg::XLEN-1:0]     mtvec,
    output logic [isa_pkg::XLEN-1:0]     mepc
);

    localparam int IDX_W = $clog2(csr_pkg::NR_CSRS);

    localparam logic [IDX_W-1:0] MSTATUS_IDX = 0;
    localparam logic [IDX_W-1:0] MTVEC_IDX   = 1;
    localparam logic [IDX_W-1:0] MEPC_IDX    = 2;
    localparam logic [IDX_W-1:0] MCAUSE_IDX  = 3;

    logic [isa_pkg::XLEN-1:0] csr_q [csr_pkg::NR_CSRS];
    logic [IDX_W-1:0]         idx;
    logic                     hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        hit = 1'b1;
        case (addr)
            csr_pkg::MSTATUS: idx = MSTATUS_IDX;
            csr_pkg::MTVEC:   idx = MTVEC_IDX;
            csr_pkg::MEPC:    idx = MEPC_IDX;
            csr_pkg::MCAUSE:  idx = MCAUSE_IDX;
            default: begin
                idx = MSTATUS_IDX;
                hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < csr_pkg::NR_CSRS; i++) begin
                csr_q[i] <= '0;
            end
            csr_q[MSTATUS_IDX] <= csr_pkg::MSTATUS_RESET;
        end else begin
            if (we && hit) begin
                csr_q[idx] <= wdata;
            end
            // Trap entry overrides a software write to mepc/mcause
            if (irq) begin
                csr_q[MEPC_IDX]   <= pc;
                csr_q[MCAUSE_IDX] <= irq_cause;
            end
        end
    end

    assign rdata = hit ? csr_q[idx] : '0;
    assign mtvec = csr_q[MTVEC_IDX];
    assign mepc  = csr_q[MEPC_IDX];

endmodule

// File: idu/idu_core.sv
`timescale 1ns/1ps

module idu_core #(
    parameter int NR_REGS = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  isa_pkg::inst_u           inst,
    commit_if.core                   commit,
    output isa_pkg::fmt_e            fmt,
    output logic [6:0]               opcode,
    output logic [2:0]               funct3,
    output logic [6:0]               funct7,
    output logic [isa_pkg::XLEN-1:0] imm,
    output logic [isa_pkg::XLEN-1:0] src1,
    output logic [isa_pkg::XLEN-1:0] src2,
    output logic [isa_pkg::XLEN-1:0] csr_rdata,
    output logic [isa_pkg::XLEN-1:0] mtvec,
    output logic [isa_pkg::XLEN-1:0] mepc
);

    localparam int AW = $clog2(NR_REGS);

    logic [isa_pkg::XLEN-1:0] word;
    logic [isa_pkg::XLEN-1:0] rs1_data;
    logic [isa_pkg::XLEN-1:0] zimm;
    logic                     is_csri;

    assign word   = inst;
    assign opcode = inst.r_view.opcode;
    assign funct3 = inst.r_view.funct3;
    assign funct7 = inst.r_view.funct7;

    always_comb begin
        case (inst.r_view.opcode)
            isa_pkg::OP:                  fmt = isa_pkg::R;
            isa_pkg::OP_IMM, isa_pkg::LOAD,
            isa_pkg::JALR, isa_pkg::SYSTEM: fmt = isa_pkg::I;
            isa_pkg::STORE:               fmt = isa_pkg::S;
            isa_pkg::BRANCH:              fmt = isa_pkg::B;
            isa_pkg::LUI, isa_pkg::AUIPC: fmt = isa_pkg::U;
            isa_pkg::JAL:                 fmt = isa_pkg::J;
            default:                      fmt = isa_pkg::NONE;
        endcase
    end

    // Sign-extended immediate per format
    always_comb begin
        case (fmt)
            isa_pkg::I: imm = {{20{word[31]}}, inst.i_view.imm12};
            isa_pkg::S: imm = {{20{word[31]}}, word[31:25], word[11:7]};
            isa_pkg::B: imm = {{19{word[31]}}, word[31], word[7], word[30:25],
                               word[11:8], 1'b0};
            isa_pkg::U: imm = {word[31:12], 12'b0};
            isa_pkg::J: imm = {{11{word[31]}}, word[31], word[19:12], word[20],
                               word[30:21], 1'b0};
            default:    imm = '0;
        endcase
    end

    // csrrwi/csrrsi/csrrci take rs1 as a 5-bit unsigned value
    assign is_csri = (inst.r_view.opcode == isa_pkg::SYSTEM) && inst.r_view.funct3[2];
    assign zimm    = {{(isa_pkg::XLEN-5){1'b0}}, inst.r_view.rs1};
    assign src1    = is_csri ? zimm : rs1_data;

    gpr_file #(
        .NR_REGS(NR_REGS)
    ) u_gpr (
        .clk   (clk),
        .rst   (rst),
        .raddr1(inst.r_view.rs1[AW-1:0]),
        .raddr2(inst.r_view.rs2[AW-1:0]),
        .waddr (inst.r_view.rd[AW-1:0]),
        .wdata (commit.wb_data),
        .we    (commit.gpr_we),
        .rdata1(rs1_data),
        .rdata2(src2)
    );

    csr_file u_csr (
        .clk      (clk),
        .rst      (rst),
        .addr     (inst.i_view.imm12),
        .wdata    (commit.wb_data),
        .we       (commit.csr_we),
        .irq      (commit.irq),
        .irq_cause(commit.irq_cause),
        .pc       (commit.pc),
        .rdata    (csr_rdata),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

endmodule

// File: idu/idu.sv
`timescale 1ns/1ps

module idu #(
    parameter int NR_REGS = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] inst,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [2:0]  fmt,
    output logic [6:0]  opcode,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output logic [31:0] imm,
    output logic [31:0] src1,
    output logic [31:0] src2,
    input  logic [31:0] wb_data,
    input  logic        gpr_we,
    input  logic        csr_we,
    input  logic        irq,
    input  logic [31:0] irq_cause,
    input  logic [31:0] pc,
    output logic [31:0] csr_rdata,
    output logic [31:0] mtvec,
    output logic [31:0] mepc
);

    logic           accept;
    logic           out_fire;
    isa_pkg::inst_u inst_q;

    commit_if commit ();

    // Accept pulse, high only in the cycle of the upstream transfer
    assign accept   = in_valid & in_ready;
    assign out_fire = out_valid & out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ready <= 1'b1;
        end else if (accept) begin
            in_ready <= 1'b0;
        end else if (out_fire) begin
            in_ready <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_fire) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inst_q <= '0;
        end else if (accept) begin
            inst_q <= inst;
        end
    end

    // Commits land on the accept edge, still addressed by the old latch
    assign commit.wb_data   = wb_data;
    assign commit.gpr_we    = gpr_we & accept;
    assign commit.csr_we    = csr_we & accept;
    assign commit.irq       = irq & accept;
    assign commit.irq_cause = irq_cause;
    assign commit.pc        = pc;

    idu_core #(
        .NR_REGS(NR_REGS)
    ) u_core (
        .clk      (clk),
        .rst      (rst),
        .inst     (inst_q),
        .commit   (commit.core),
        .fmt      (fmt),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .imm      (imm),
        .src1     (src1),
        .src2     (src2),
        .csr_rdata(csr_rdata),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

endmodule

// File: design/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] inst,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [2:0]  fmt,
    output logic [6:0]  opcode,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output logic [31:0] imm,
    output logic [31:0] src1,
    output logic [31:0] src2,
    input  logic [31:0] wb_data,
    input  logic        gpr_we,
    input  logic        csr_we,
    input  logic        irq,
    input  logic [31:0] irq_cause,
    input  logic [31:0] pc,
    output logic [31:0] csr_rdata,
    output logic [31:0] mtvec,
    output logic [31:0] mepc
);

    // RV32E register count
    localparam int NR_REGS = 1 << isa_pkg::REG_ADDR_W;

    idu #(
        .NR_REGS(NR_REGS)
    ) u_idu (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .inst     (inst),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .fmt      (fmt),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .imm      (imm),
        .src1     (src1),
        .src2     (src2),
        .wb_data  (wb_data),
        .gpr_we   (gpr_we),
        .csr_we   (csr_we),
        .irq      (irq),
        .irq_cause(irq_cause),
        .pc       (pc),
        .csr_rdata(csr_rdata),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

endmodule

// File: sim/tb_decode.sv
`timescale 1ns/1ps

module tb_decode;

    localparam int CLK_PERIOD = 10;
    // Instructions issued by all tests together
    localparam int N_INSTS = 1 + 4 + 30 + 18 + 9 + 4;
    localparam int CYCLES_PER_INST = 200;

    localparam logic [6:0] DEC_OPS [10] = '{
        isa_pkg::OP, isa_pkg::OP_IMM, isa_pkg::LOAD, isa_pkg::STORE, isa_pkg::BRANCH,
        isa_pkg::JAL, isa_pkg::JALR, isa_pkg::LUI, isa_pkg::AUIPC, 7'b0001111
    };

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] inst;
    logic        out_valid;
    logic        out_ready;
    logic [2:0]  fmt;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] wb_data;
    logic        gpr_we;
    logic        csr_we;
    logic        irq;
    logic [31:0] irq_cause;
    logic [31:0] pc;
    logic [31:0] csr_rdata;
    logic [31:0] mtvec;
    logic [31:0] mepc;

    logic [31:0] lfsr;
    logic [31:0] gpr_sh [16];
    logic [31:0] mstatus_sh;
    logic [31:0] mtvec_sh;
    logic [31:0] mepc_sh;
    logic [31:0] mcause_sh;
    logic [31:0] latched;
    int          errors;
    int          checks;

    decode_top uut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .inst     (inst),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .fmt      (fmt),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .imm      (imm),
        .src1     (src1),
        .src2     (src2),
        .wb_data  (wb_data),
        .gpr_we   (gpr_we),
        .csr_we   (csr_we),
        .irq      (irq),
        .irq_cause(irq_cause),
        .pc       (pc),
        .csr_rdata(csr_rdata),
        .mtvec    (mtvec),
        .mepc     (mepc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [2:0] classify_fmt(input logic [31:0] w);
        case (w[6:0])
            isa_pkg::OP:                   return isa_pkg::R;
            isa_pkg::OP_IMM, isa_pkg::LOAD,
            isa_pkg::JALR, isa_pkg::SYSTEM: return isa_pkg::I;
            isa_pkg::STORE:                return isa_pkg::S;
            isa_pkg::BRANCH:               return isa_pkg::B;
            isa_pkg::LUI, isa_pkg::AUIPC:  return isa_pkg::U;
            isa_pkg::JAL:                  return isa_pkg::J;
            default:                       return isa_pkg::NONE;
        endcase
    endfunction

    function automatic logic [31:0] build_imm(input logic [31:0] w);
        case (classify_fmt(w))
            isa_pkg::I: return {{20{w[31]}}, w[31:20]};
            isa_pkg::S: return {{20{w[31]}}, w[31:25], w[11:7]};
            isa_pkg::B: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            isa_pkg::U: return {w[31:12], 12'h000};
            isa_pkg::J: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] read_csr_shadow(input logic [11:0] a);
        case (a)
            12'h300: return mstatus_sh;
            12'h305: return mtvec_sh;
            12'h341: return mepc_sh;
            12'h342: return mcause_sh;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] csr_word(input logic [11:0] a, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {a, rs1, f3, rd, isa_pkg::SYSTEM};
    endfunction

    // Commit goes to the instruction that was latched before the accept
    task automatic apply_commit(input logic gwe, input logic cwe, input logic irq_v,
                                input logic [31:0] data, input logic [31:0] cause,
                                input logic [31:0] pc_v);
        if (gwe && latched[10:7] != 4'd0) begin
            gpr_sh[latched[10:7]] = data;
        end
        if (cwe) begin
            case (latched[31:20])
                12'h300: mstatus_sh = data;
                12'h305: mtvec_sh = data;
                12'h341: mepc_sh = data;
                12'h342: mcause_sh = data;
                default: ;
            endcase
        end
        if (irq_v) begin
            mepc_sh   = pc_v;
            mcause_sh = cause;
        end
    endtask

    task automatic compare(input string test, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test, field, exp, act);
        end
    endtask

    task automatic check_decode(input string test);
        logic [31:0] w;
        logic [31:0] exp_src1;
        w = latched;
        if (w[6:0] == isa_pkg::SYSTEM && w[14]) begin
            exp_src1 = {27'd0, w[19:15]};
        end else begin
            exp_src1 = gpr_sh[w[18:15]];
        end
        compare(test, "fmt", {29'd0, classify_fmt(w)}, {29'd0, fmt});
        compare(test, "opcode", {25'd0, w[6:0]}, {25'd0, opcode});
        compare(test, "funct3", {29'd0, w[14:12]}, {29'd0, funct3});
        compare(test, "funct7", {25'd0, w[31:25]}, {25'd0, funct7});
        compare(test, "imm", build_imm(w), imm);
        compare(test, "src1", exp_src1, src1);
        compare(test, "src2", gpr_sh[w[23:20]], src2);
        compare(test, "csr_rdata", read_csr_shadow(w[31:20]), csr_rdata);
        compare(test, "mtvec", mtvec_sh, mtvec);
        compare(test, "mepc", mepc_sh, mepc);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake driver, called 1 ns after a rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic issue(input string test, input logic [31:0] word, input int stall,
                         input logic gwe, input logic cwe, input logic irq_v,
                         input logic [31:0] data, input logic [31:0] cause,
                         input logic [31:0] pc_v);
        logic [31:0] snap_imm;
        logic [31:0] snap_src1;
        logic [31:0] snap_src2;
        logic [31:0] snap_csr;
        in_valid  = 1'b1;
        inst      = word;
        gpr_we    = gwe;
        csr_we    = cwe;
        irq       = irq_v;
        wb_data   = data;
        irq_cause = cause;
        pc        = pc_v;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        compare(test, "out_valid before accept", 32'd0, {31'd0, out_valid});
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        gpr_we   = 1'b0;
        csr_we   = 1'b0;
        irq      = 1'b0;
        inst     = rand_bits(32);
        wb_data  = rand_bits(32);
        apply_commit(gwe, cwe, irq_v, data, cause, pc_v);
        latched = word;
        compare(test, "out_valid after accept", 32'd1, {31'd0, out_valid});
        compare(test, "in_ready after accept", 32'd0, {31'd0, in_ready});
        check_decode(test);
        snap_imm  = imm;
        snap_src1 = src1;
        snap_src2 = src2;
        snap_csr  = csr_rdata;
        // Back-pressure, everything holds
        for (int i = 0; i < stall; i++) begin
            // Commit enables without an accept must not write
            gpr_we    = 1'b1;
            csr_we    = 1'b1;
            irq       = 1'b1;
            wb_data   = rand_bits(32);
            pc        = rand_bits(32);
            @(posedge clk);
            #1;
            compare(test, "out_valid held", 32'd1, {31'd0, out_valid});
            compare(test, "in_ready held", 32'd0, {31'd0, in_ready});
            compare(test, "imm held", snap_imm, imm);
            compare(test, "src1 held", snap_src1, src1);
            compare(test, "src2 held", snap_src2, src2);
            compare(test, "csr_rdata held", snap_csr, csr_rdata);
            compare(test, "mepc held", mepc_sh, mepc);
        end
        gpr_we    = 1'b0;
        csr_we    = 1'b0;
        irq       = 1'b0;
        out_ready = 1'b1;
        @(posedge clk);
        #1;
        out_ready = 1'b0;
        compare(test, "out_valid after handshake", 32'd0, {31'd0, out_valid});
        compare(test, "in_ready after handshake", 32'd1, {31'd0, in_ready});
    endtask

    task automatic send(input string test, input logic [31:0] word, input int stall);
        issue(test, word, stall, 1'b0, 1'b0, 1'b0, rand_bits(32), 32'd0, 32'd0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_state();
        compare("reset", "in_ready", 32'd1, {31'd0, in_ready});
        compare("reset", "out_valid", 32'd0, {31'd0, out_valid});
        send("reset", csr_word(12'h300, 5'd0, 3'b010, 5'd1), 0);
        compare("reset", "mstatus", 32'h0000_1800, csr_rdata);
    endtask

    task automatic handshake_timing();
        logic [31:0] r;
        int          stall;
        for (int i = 0; i < 4; i++) begin
            r     = rand_bits(25);
            stall = 1 + int'(rand_bits(4));
            send("handshake", {r[24:0], isa_pkg::OP_IMM}, stall);
        end
    endtask

    task automatic field_decode();
        logic [31:0] r;
        for (int i = 0; i < 30; i++) begin
            r = rand_bits(25);
            send("decode", {r[24:0], DEC_OPS[i % 10]}, 0);
        end
    endtask

    task automatic register_commit();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  prev_rd;
        prev_rd = 5'd0;
        // Each word reads back the register that its own accept wrote
        for (int i = 0; i < 16; i++) begin
            r  = rand_bits(9);
            rd = {1'b0, r[3:0]};
            issue("gpr", {7'd0, r[8:4], prev_rd, 3'b000, rd, isa_pkg::OP}, 0,
                  1'b1, 1'b0, 1'b0, rand_bits(32), 32'd0, 32'd0);
            prev_rd = rd;
        end
        send("gpr x0", {7'd0, 5'd1, 5'd2, 3'b000, 5'd0, isa_pkg::OP}, 0);
        issue("gpr x0", {7'd0, 5'd0, 5'd0, 3'b000, 5'd3, isa_pkg::OP}, 0,
              1'b1, 1'b0, 1'b0, 32'hffff_ffff, 32'd0, 32'd0);
        compare("gpr x0", "src1", 32'd0, src1);
        compare("gpr x0", "src2", 32'd0, src2);
    endtask

    task automatic csr_write_zimm();
        logic [11:0] addrs [4];
        logic [31:0] d;
        logic [31:0] r;
        addrs = '{12'h300, 12'h305, 12'h341, 12'h342};
        for (int i = 0; i < 4; i++) begin
            send("csr", csr_word(addrs[i], 5'd0, 3'b001, 5'd0), 0);
            d = rand_bits(32);
            issue("csr", csr_word(addrs[i], 5'd0, 3'b010, 5'd2), 0,
                  1'b0, 1'b1, 1'b0, d, 32'd0, 32'd0);
            compare("csr", "csr_rdata", d, csr_rdata);
            if (addrs[i] == 12'h305) begin
                compare("csr", "mtvec port", d, mtvec);
            end
            if (addrs[i] == 12'h341) begin
                compare("csr", "mepc port", d, mepc);
            end
        end
        r = rand_bits(5);
        send("zimm", csr_word(12'h305, r[4:0], 3'b101, 5'd3), 0);
        compare("zimm", "src1", {27'd0, r[4:0]}, src1);
    endtask

    task automatic interrupt_entry();
        logic [31:0] d;
        logic [31:0] c;
        logic [31:0] p;
        logic [31:0] r;
        logic [31:0] mstatus_old;
        logic [31:0] mtvec_old;
        d           = rand_bits(32);
        r           = rand_bits(31);
        c           = {1'b1, r[30:0]};
        r           = rand_bits(30);
        p           = {r[29:0], 2'b00};
        mstatus_old = mstatus_sh;
        mtvec_old   = mtvec_sh;
        send("irq", csr_word(12'h341, 5'd0, 3'b001, 5'd0), 0);
        // Software write to mepc in the same accept as the interrupt
        issue("irq", csr_word(12'h342, 5'd0, 3'b010, 5'd4), 0,
              1'b0, 1'b1, 1'b1, d, c, p);
        compare("irq", "mepc", p, mepc);
        compare("irq", "mcause", c, csr_rdata);
        send("irq", csr_word(12'h300, 5'd0, 3'b010, 5'd5), 0);
        compare("irq", "mstatus", mstatus_old, csr_rdata);
        send("irq", csr_word(12'h305, 5'd0, 3'b010, 5'd6), 0);
        compare("irq", "mtvec", mtvec_old, csr_rdata);
    endtask

    initial begin
        lfsr       = 32'hc864_46c9;
        errors     = 0;
        checks     = 0;
        latched    = 32'h0;
        mstatus_sh = 32'h0000_1800;
        mtvec_sh   = 32'h0;
        mepc_sh    = 32'h0;
        mcause_sh  = 32'h0;
        for (int i = 0; i < 16; i++) begin
            gpr_sh[i] = 32'h0;
        end
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        inst      = 32'h0;
        out_ready = 1'b0;
        wb_data   = 32'h0;
        gpr_we    = 1'b0;
        csr_we    = 1'b0;
        irq       = 1'b0;
        irq_cause = 32'h0;
        pc        = 32'h0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_state();
        handshake_timing();
        field_decode();
        register_commit();
        csr_write_zimm();
        interrupt_entry();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((N_INSTS * CYCLES_PER_INST + 100) * CLK_PERIOD);
        $display("Timeout: the DUT did not finish its handshakes in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: tb.f
common/isa_pkg.sv
common/csr_pkg.sv
common/commit_if.sv
idu/gpr_file.sv
idu/csr_file.sv
idu/idu_core.sv
idu/idu.sv
design/decode_top.sv
sim/tb_decode.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_decode -o tb_decode_sim
./obj_dir/tb_decode_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
